// ==== hdl/divu_pkg.sv ====
`default_nettype none

package divu_pkg;

  // Request tag carried through a lane to the output
  localparam int ID_W = 4;

  typedef logic [ID_W-1:0] id_t;

  // Lane FSM
  typedef enum logic [1:0] {
    LANE_IDLE,
    LANE_RUN,
    LANE_HOLD
  } lane_state_e;

endpackage

`default_nettype wire

// ==== hdl/divu_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_dispatch #(
  parameter int WIDTH = 32,
  parameter int LANES = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             en,
  input  wire logic [WIDTH-1:0] dividend,
  input  wire logic [WIDTH-1:0] divisor,
  input  wire divu_pkg::id_t    id,
  input  wire logic [LANES-1:0] occupied,
  output logic                  busy,
  output logic [LANES-1:0]      start,
  output logic [WIDTH-1:0]      op_dividend,
  output logic [WIDTH-1:0]      op_divisor,
  output divu_pkg::id_t         op_id
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [LANES-1:0] free;
  logic [PTR_W-1:0] last;
  logic [PTR_W-1:0] pick;
  logic             accept;

  // A lane with its start still in flight is not free yet
  assign free   = ~occupied & ~start;
  assign busy   = ~|free;
  assign accept = en & ~busy;

  // Round-robin search from the lane after the last grant
  always_comb begin
    logic found;
    int   idx;
    found = 1'b0;
    idx   = 0;
    pick  = last;
    for (int i = 1; i <= LANES; i++) begin
      idx = int'(last) + i;
      if (idx >= LANES) begin
        idx = idx - LANES;
      end
      if (!found && free[idx]) begin
        found = 1'b1;
        pick  = PTR_W'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      start <= '0;
      // First grant after reset goes to lane 0
      last  <= PTR_W'(LANES - 1);
    end else begin
      start <= '0;
      if (accept) begin
        start[pick] <= 1'b1;
        last        <= pick;
      end
    end
  end

  // Operands shared by all lanes, valid alongside start
  always_ff @(posedge clk) begin
    if (accept) begin
      op_dividend <= dividend;
      op_divisor  <= divisor;
      op_id       <= id;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/divu_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_lane #(
  parameter int WIDTH = 32
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             start,
  input  wire logic [WIDTH-1:0] dividend,
  input  wire logic [WIDTH-1:0] divisor,
  input  wire divu_pkg::id_t    id,
  input  wire logic             drain,
  output logic                  occupied,
  output logic                  done,
  output logic                  dz,
  output logic [WIDTH-1:0]      quotient,
  output logic [WIDTH-1:0]      remainder,
  output divu_pkg::id_t         lane_id
);

  localparam int CNT_W = $clog2(WIDTH + 1);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(WIDTH);

  divu_pkg::lane_state_e state;

  logic [CNT_W-1:0] cnt;
  logic [WIDTH-1:0] div_r;
  logic [WIDTH:0]   shifted;
  logic [WIDTH:0]   diff;
  logic             fits;
  logic             load;
  logic             step;
  logic             zero_div;

  assign occupied = (state != divu_pkg::LANE_IDLE);
  assign done     = (state == divu_pkg::LANE_HOLD);

  assign zero_div = (divisor == '0);
  assign load     = (state == divu_pkg::LANE_IDLE) && start;
  assign step     = (state == divu_pkg::LANE_RUN) && (cnt != LAST_CNT);

  // Next dividend bit moves from the quotient register into the remainder
  assign shifted = {remainder, quotient[WIDTH-1]};
  assign diff    = shifted - {1'b0, div_r};
  assign fits    = ~diff[WIDTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= divu_pkg::LANE_IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        divu_pkg::LANE_IDLE: begin
          if (start) begin
            // Zero divisor only spends the closing cycle in the run
            cnt   <= zero_div ? LAST_CNT : '0;
            state <= divu_pkg::LANE_RUN;
          end
        end
        divu_pkg::LANE_RUN: begin
          // Closing cycle of the run, result already in place
          if (cnt == LAST_CNT) begin
            state <= divu_pkg::LANE_HOLD;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        divu_pkg::LANE_HOLD: begin
          if (drain) begin
            state <= divu_pkg::LANE_IDLE;
          end
        end
        default: begin
          state <= divu_pkg::LANE_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      lane_id <= id;
      div_r   <= divisor;
      dz      <= zero_div;
      if (zero_div) begin
        // Fixed divide-by-zero result
        quotient  <= '1;
        remainder <= dividend;
      end else begin
        quotient  <= dividend;
        remainder <= '0;
      end
    end else if (step) begin
      // Restore by keeping the shifted value when the divisor does not fit
      if (fits) begin
        remainder <= diff[WIDTH-1:0];
      end else begin
        remainder <= shifted[WIDTH-1:0];
      end
      quotient <= {quotient[WIDTH-2:0], fits};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/divu_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_collect #(
  parameter int WIDTH = 32,
  parameter int LANES = 4
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic [LANES-1:0]                done,
  input  wire logic [LANES-1:0]                dz,
  input  wire logic [LANES*WIDTH-1:0]          quotient_in,
  input  wire logic [LANES*WIDTH-1:0]          remainder_in,
  input  wire logic [LANES*divu_pkg::ID_W-1:0] id_in,
  output logic [LANES-1:0]                     drain,
  output logic                                 out_valid,
  output logic                                 out_div_zero,
  output divu_pkg::id_t                        out_id,
  output logic [WIDTH-1:0]                     quotient,
  output logic [WIDTH-1:0]                     remainder
);

  localparam int PTR_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [LANES-1:0] ready;
  logic [PTR_W-1:0] last;
  logic [PTR_W-1:0] pick;
  logic             pick_valid;

  // A lane being drained still shows done for one more cycle
  assign ready = done & ~drain;

  always_comb begin
    int idx;
    idx        = 0;
    pick       = last;
    pick_valid = 1'b0;
    for (int i = 1; i <= LANES; i++) begin
      idx = int'(last) + i;
      if (idx >= LANES) begin
        idx = idx - LANES;
      end
      if (!pick_valid && ready[idx]) begin
        pick_valid = 1'b1;
        pick       = PTR_W'(idx);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drain        <= '0;
      out_valid    <= 1'b0;
      out_div_zero <= 1'b0;
      last         <= PTR_W'(LANES - 1);
    end else begin
      drain        <= '0;
      out_valid    <= 1'b0;
      out_div_zero <= 1'b0;
      if (pick_valid) begin
        drain[pick]  <= 1'b1;
        out_valid    <= ~dz[pick];
        out_div_zero <= dz[pick];
        last         <= pick;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pick_valid) begin
      out_id    <= id_in[pick*divu_pkg::ID_W +: divu_pkg::ID_W];
      quotient  <= quotient_in[pick*WIDTH +: WIDTH];
      remainder <= remainder_in[pick*WIDTH +: WIDTH];
    end
  end

endmodule

`default_nettype wire

// ==== hdl/divu_farm.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_farm #(
  parameter int WIDTH = 32,
  parameter int LANES = 4
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             en,
  input  wire logic [WIDTH-1:0] dividend,
  input  wire logic [WIDTH-1:0] divisor,
  input  wire divu_pkg::id_t    id,
  output logic                  busy,
  output logic                  out_valid,
  output logic                  out_div_zero,
  output divu_pkg::id_t         out_id,
  output logic [WIDTH-1:0]      quotient,
  output logic [WIDTH-1:0]      remainder
);

  wire logic [LANES-1:0] start;
  wire logic [LANES-1:0] occupied;
  wire logic [LANES-1:0] done;
  wire logic [LANES-1:0] dz;
  wire logic [LANES-1:0] drain;

  wire logic [WIDTH-1:0] op_dividend;
  wire logic [WIDTH-1:0] op_divisor;
  wire divu_pkg::id_t    op_id;

  // Lane results, flattened lane by lane
  wire logic [LANES*WIDTH-1:0]          lane_quotient;
  wire logic [LANES*WIDTH-1:0]          lane_remainder;
  wire logic [LANES*divu_pkg::ID_W-1:0] lane_id;

  divu_dispatch #(
    .WIDTH(WIDTH),
    .LANES(LANES)
  ) u_dispatch (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .dividend   (dividend),
    .divisor    (divisor),
    .id         (id),
    .occupied   (occupied),
    .busy       (busy),
    .start      (start),
    .op_dividend(op_dividend),
    .op_divisor (op_divisor),
    .op_id      (op_id)
  );

  for (genvar g = 0; g < LANES; g++) begin : g_lane
    divu_lane #(
      .WIDTH(WIDTH)
    ) u_lane (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start[g]),
      .dividend (op_dividend),
      .divisor  (op_divisor),
      .id       (op_id),
      .drain    (drain[g]),
      .occupied (occupied[g]),
      .done     (done[g]),
      .dz       (dz[g]),
      .quotient (lane_quotient[g*WIDTH +: WIDTH]),
      .remainder(lane_remainder[g*WIDTH +: WIDTH]),
      .lane_id  (lane_id[g*divu_pkg::ID_W +: divu_pkg::ID_W])
    );
  end

  divu_collect #(
    .WIDTH(WIDTH),
    .LANES(LANES)
  ) u_collect (
    .clk         (clk),
    .rst_n       (rst_n),
    .done        (done),
    .dz          (dz),
    .quotient_in (lane_quotient),
    .remainder_in(lane_remainder),
    .id_in       (lane_id),
    .drain       (drain),
    .out_valid   (out_valid),
    .out_div_zero(out_div_zero),
    .out_id      (out_id),
    .quotient    (quotient),
    .remainder   (remainder)
  );

endmodule

`default_nettype wire

// ==== sim/divu_farm_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_farm_checker #(
  parameter int WIDTH = 32
) (
  input wire logic                  clk,
  input wire logic                  rst_n,
  input wire logic                  start,
  input wire logic                  drain,
  input wire logic                  done,
  input wire logic                  dz,
  input wire logic [WIDTH-1:0]      quotient,
  input wire logic [WIDTH-1:0]      remainder,
  input wire divu_pkg::id_t         lane_id,
  input wire divu_pkg::lane_state_e state
);

  logic started;
  int   run_cycles;

  // Set by start, cleared once the result is drained
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (start) begin
      started <= 1'b1;
    end else if (drain) begin
      started <= 1'b0;
    end
  end

  // Cycles since the start edge while the lane iterates
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run_cycles <= 0;
    end else if (start) begin
      run_cycles <= 1;
    end else if (state == divu_pkg::LANE_RUN) begin
      run_cycles <= run_cycles + 1;
    end
  end

  a_done_after_start: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(done) |-> started)
    else $error("lane done rose without a start");

  a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
    done && $past(done) |-> $stable({dz, quotient, remainder, lane_id}))
    else $error("lane result changed while held");

  a_run_length: assert property (@(posedge clk) disable iff (!rst_n)
    state == divu_pkg::LANE_RUN |-> run_cycles <= WIDTH + 1)
    else $error("lane still running more than WIDTH+1 cycles after start");

  a_drain_when_done: assert property (@(posedge clk) disable iff (!rst_n)
    drain |-> done)
    else $error("drain reached a lane without a result");

endmodule

bind divu_lane divu_farm_checker #(
  .WIDTH(WIDTH)
) u_checker (
  .clk      (clk),
  .rst_n    (rst_n),
  .start    (start),
  .drain    (drain),
  .done     (done),
  .dz       (dz),
  .quotient (quotient),
  .remainder(remainder),
  .lane_id  (lane_id),
  .state    (state)
);

`default_nettype wire

// ==== sim/divu_farm_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module divu_farm_tb;

  localparam int WIDTH    = 32;
  localparam int LANES    = 4;
  localparam int TAGS     = 1 << divu_pkg::ID_W;
  // Accepting edge to output edge for a lone request
  localparam int LAT_DIV  = WIDTH + 3;
  // Zero divisor skips the run
  localparam int LAT_DZ   = 3;
  localparam int WAIT_MAX = 400;

  logic             clk;
  logic             rst_n;
  logic             en;
  logic [WIDTH-1:0] dividend;
  logic [WIDTH-1:0] divisor;
  divu_pkg::id_t    id;
  logic             busy;
  logic             out_valid;
  logic             out_div_zero;
  divu_pkg::id_t    out_id;
  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  // Scoreboard indexed by tag
  logic [WIDTH-1:0] exp_q [TAGS];
  logic [WIDTH-1:0] exp_r [TAGS];
  logic             exp_dz [TAGS];
  logic             pending [TAGS];
  int               accept_cycle [TAGS];

  logic        check_latency;
  logic        timed_out;
  logic [31:0] lfsr;
  int          cycle;
  int          errors;
  int          checks;
  int          results;
  int          tests;

  divu_farm #(
    .WIDTH(WIDTH),
    .LANES(LANES)
  ) DUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .dividend    (dividend),
    .divisor     (divisor),
    .id          (id),
    .busy        (busy),
    .out_valid   (out_valid),
    .out_div_zero(out_div_zero),
    .out_id      (out_id),
    .quotient    (quotient),
    .remainder   (remainder)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic int count_pending();
    int n;
    n = 0;
    for (int t = 0; t < TAGS; t++) begin
      if (pending[t]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic note_error(input string what);
    $display("[ERROR] %0t %s", $time, what);
    errors++;
  endtask

  task automatic check_word(input string name, input logic [WIDTH-1:0] got,
                            input logic [WIDTH-1:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // Output monitor, sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && (out_valid || out_div_zero)) begin
      assert (!(out_valid && out_div_zero))
        else note_error("out_valid and out_div_zero high in the same cycle");
      assert (pending[out_id])
        else note_error($sformatf("result for tag %0d that is not outstanding", out_id));
      if (pending[out_id]) begin
        check_word("out_div_zero", WIDTH'(out_div_zero), WIDTH'(exp_dz[out_id]));
        check_word("quotient", quotient, exp_q[out_id]);
        check_word("remainder", remainder, exp_r[out_id]);
        if (check_latency) begin
          check_word("latency", WIDTH'(cycle - accept_cycle[out_id]),
                     WIDTH'(exp_dz[out_id] ? LAT_DZ : LAT_DIV));
        end
        pending[out_id] = 1'b0;
        results++;
      end
    end
  end

  // Waits for a free lane and a free tag, then strobes en for one cycle
  task automatic send(input logic [WIDTH-1:0] a, input logic [WIDTH-1:0] b,
                      input divu_pkg::id_t t);
    int waited;
    waited = 0;
    while ((busy || pending[t]) && !timed_out) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_MAX) begin
        note_error($sformatf("timed out waiting to issue tag %0d", t));
        timed_out = 1'b1;
      end
    end
    if (timed_out) begin
      return;
    end
    exp_dz[t] = (b == '0);
    if (b == '0) begin
      exp_q[t] = '1;
      exp_r[t] = a;
    end else begin
      exp_q[t] = a / b;
      exp_r[t] = a % b;
    end
    pending[t]      = 1'b1;
    accept_cycle[t] = cycle + 1;
    en       = 1'b1;
    dividend = a;
    divisor  = b;
    id       = t;
    @(posedge clk);
    #2;
    en = 1'b0;
  endtask

  task automatic wait_all(input string what);
    int waited;
    waited = 0;
    while (count_pending() != 0 && !timed_out) begin
      @(posedge clk);
      #2;
      waited++;
      if (waited > WAIT_MAX) begin
        note_error($sformatf("timed out waiting for results of %s", what));
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests++;
    $display("test %-14s %0d errors", name, errors - errors_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_word("busy", WIDTH'(busy), '0);
      check_word("out_valid", WIDTH'(out_valid), '0);
      check_word("out_div_zero", WIDTH'(out_div_zero), '0);
    end
    @(posedge clk);
    #2;
    finish_test("reset_idle", e0);
  endtask

  task automatic test_lone();
    logic [WIDTH-1:0] a_list [10];
    logic [WIDTH-1:0] b_list [10];
    int e0;
    e0 = errors;
    a_list = '{32'd42, 32'd10, 32'd5, 32'd42, 32'd42, 32'd0, 32'hffff_ffff,
               32'hffff_ffff, 32'd256, 32'd100};
    b_list = '{32'd7, 32'd3, 32'd10, 32'd1, 32'd42, 32'd7, 32'd2,
               32'hffff_ffff, 32'd16, 32'd7};
    check_latency = 1'b1;
    for (int i = 0; i < 10; i++) begin
      send(a_list[i], b_list[i], divu_pkg::id_t'(i));
      wait_all("lone division");
    end
    check_latency = 1'b0;
    finish_test("lone", e0);
  endtask

  task automatic test_zero();
    int e0;
    e0 = errors;
    check_latency = 1'b1;
    send(32'h1234_5678, '0, divu_pkg::id_t'(3));
    wait_all("divide by zero");
    send(32'h0000_0000, '0, divu_pkg::id_t'(12));
    wait_all("divide by zero");
    check_latency = 1'b0;
    finish_test("div_zero", e0);
  endtask

  task automatic test_full();
    int e0;
    e0 = errors;
    for (int i = 0; i < LANES; i++) begin
      send(WIDTH'(32'h00ff_1234 * (i + 1)), WIDTH'(3 + i), divu_pkg::id_t'(4 + i));
    end
    assert (busy === 1'b1) else note_error("busy low with every lane taken");
    // Dropped request, tag 15 must never come out
    en       = 1'b1;
    dividend = 32'd77;
    divisor  = 32'd7;
    id       = divu_pkg::id_t'(15);
    @(posedge clk);
    #2;
    en = 1'b0;
    wait_all("full farm");
    repeat (LAT_DIV + 2) @(posedge clk);
    #2;
    finish_test("full", e0);
  endtask

  task automatic test_random();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sel;
    int          tag;
    int          e0;
    e0  = errors;
    tag = 0;
    for (int n = 0; n < 40; n++) begin
      take_bits(32, a);
      take_bits(3, sel);
      if (sel == 0) begin
        b = '0;
      end else if (sel < 4) begin
        take_bits(8, b);
      end else begin
        take_bits(32, b);
      end
      send(a, b, divu_pkg::id_t'(tag));
      tag = (tag + 1) % TAGS;
    end
    wait_all("random requests");
    finish_test("random", e0);
  endtask

  task automatic test_collide();
    int e0;
    e0 = errors;
    for (int i = 0; i < 3; i++) begin
      send(WIDTH'(32'hdead_beef - i), WIDTH'(5 + i), divu_pkg::id_t'(8 + i));
    end
    // Zero divide lands its done on the first lane's done
    repeat (29) @(posedge clk);
    #2;
    send(32'h0bad_cafe, '0, divu_pkg::id_t'(11));
    wait_all("collision");
    finish_test("collide", e0);
  endtask

  initial begin
    rst_n         = 1'b0;
    en            = 1'b0;
    dividend      = '0;
    divisor       = '0;
    id            = '0;
    lfsr          = 32'hbd19_7ab8;
    cycle         = 0;
    errors        = 0;
    checks        = 0;
    results       = 0;
    tests         = 0;
    check_latency = 1'b0;
    timed_out     = 1'b0;
    for (int t = 0; t < TAGS; t++) begin
      pending[t] = 1'b0;
    end
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset();
    test_lone();
    test_zero();
    test_full();
    test_random();
    test_collide();

    $display("tests %0d, checks %0d, results %0d, errors %0d",
             tests, checks, results, errors);
    if (errors == 0 && !timed_out) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== divu_farm.f ====
hdl/divu_pkg.sv
hdl/divu_dispatch.sv
hdl/divu_lane.sv
hdl/divu_collect.sv
hdl/divu_farm.sv
sim/divu_farm_checker.sv
sim/divu_farm_tb.sv

// ==== Makefile ====
TOP = divu_farm_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
	  --top-module $(TOP) -f divu_farm.f -Mdir obj_dir

# The run fails unless the pass line shows up in the simulator output
run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
